// ==== source/exu_config.svh ====
/*
 build-time sizing for the execute slice
 EXU_XLEN other than 32 is not supported by the immediate decode
 EXU_FIFO_PTR_WIDTH must equal log2 of EXU_FIFO_DEPTH
 EXU_FIFO_DEPTH must be a power of two (2, 4 or 8)
 */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data and pc width
`define EXU_XLEN 32

// register file address width
`define EXU_REG_ADDR_WIDTH 5

// issue queue entries and index width
`define EXU_FIFO_DEPTH 4
`define EXU_FIFO_PTR_WIDTH 2

`endif

// ==== source/exu_pkg.sv ====
/*
 shared types of the execute slice
 opcode_e holds only the RV32I major opcodes this slice executes
 alu_op_e has no lui, auipc or jump entries
 those are ADD with operands picked by the decoder
 */
package exu_pkg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // alu operation
    // low 3 bits follow funct3, bit 3 follows funct7[5]
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_e;

endpackage

// ==== source/idu_decode.sv ====
/*
 RV32I decoder for OP, OP_IMM, LUI, AUIPC, JAL and JALR
 other opcodes are accepted and dropped without an output
 funct7 bits other than bit 30 are not checked
 jal and jalr produce only the link value, no target
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module idu_decode (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           int_assert_i,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    input  logic [`EXU_XLEN-1:0]           instr_i,
    input  logic [`EXU_XLEN-1:0]           pc_i,
    input  logic [`EXU_XLEN-1:0]           rs1_data_i,
    input  logic [`EXU_XLEN-1:0]           rs2_data_i,
    output logic                           dec_valid_o,
    input  logic                           dec_ready_i,
    output exu_pkg::alu_op_e               dec_alu_op_o,
    output logic [`EXU_XLEN-1:0]           dec_op1_o,
    output logic [`EXU_XLEN-1:0]           dec_op2_o,
    output logic [`EXU_REG_ADDR_WIDTH-1:0] dec_rd_o
);

    // instruction fields
    exu_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic             funct7_b30;
    logic [`EXU_XLEN-1:0] imm_i;
    logic [`EXU_XLEN-1:0] imm_u;

    // decode result before the output register
    logic                 legal;
    exu_pkg::alu_op_e     nxt_alu_op;
    logic [`EXU_XLEN-1:0] nxt_op1;
    logic [`EXU_XLEN-1:0] nxt_op2;

    logic accept;

    // funct3 to alu op, alt selects sub or sra
    function automatic exu_pkg::alu_op_e alu_op_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_op_sel = alt ? exu_pkg::SUB : exu_pkg::ADD;
            3'b001:  alu_op_sel = exu_pkg::SLL;
            3'b010:  alu_op_sel = exu_pkg::SLT;
            3'b011:  alu_op_sel = exu_pkg::SLTU;
            3'b100:  alu_op_sel = exu_pkg::XOR;
            3'b101:  alu_op_sel = alt ? exu_pkg::SRA : exu_pkg::SRL;
            3'b110:  alu_op_sel = exu_pkg::OR;
            default: alu_op_sel = exu_pkg::AND;
        endcase
    endfunction

    assign opcode     = exu_pkg::opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7_b30 = instr_i[30];
    // sign-extended I-type, shamt is imm_i[4:0]
    assign imm_i      = {{(`EXU_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u      = {instr_i[31:12], 12'b0};

    always_comb begin
        legal      = 1'b1;
        nxt_alu_op = exu_pkg::ADD;
        nxt_op1    = '0;
        nxt_op2    = '0;
        case (opcode)
            exu_pkg::OP: begin
                nxt_alu_op = alu_op_sel(funct3, funct7_b30);
                nxt_op1    = rs1_data_i;
                nxt_op2    = rs2_data_i;
            end
            exu_pkg::OP_IMM: begin
                // bit 30 is part of the immediate except for shift right
                nxt_alu_op = alu_op_sel(funct3, funct7_b30 && (funct3 == 3'b101));
                nxt_op1    = rs1_data_i;
                nxt_op2    = imm_i;
            end
            exu_pkg::LUI: begin
                nxt_op2 = imm_u;
            end
            exu_pkg::AUIPC: begin
                nxt_op1 = pc_i;
                nxt_op2 = imm_u;
            end
            exu_pkg::JAL, exu_pkg::JALR: begin
                // link value pc + 4
                nxt_op1 = pc_i;
                nxt_op2 = `EXU_XLEN'd4;
            end
            default: legal = 1'b0;
        endcase
    end

    // take a new word when empty or draining this cycle, never on interrupt
    assign in_ready_o = !int_assert_i && (!dec_valid_o || dec_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i || int_assert_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            // illegal words leave the register empty
            dec_valid_o <= in_valid_i && legal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_alu_op_o <= nxt_alu_op;
            dec_op1_o    <= nxt_op1;
            dec_op2_o    <= nxt_op2;
            dec_rd_o     <= instr_i[11:7];
        end
    end

endmodule

// ==== source/exu_issue_fifo.sv ====
/*
 issue queue of `EXU_FIFO_DEPTH decoded operations
 head is shown combinationally, write and read may share a cycle
 a write while full is ignored, interrupt empties the queue
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module exu_issue_fifo (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           int_assert_i,
    input  logic                           wr_valid_i,
    output logic                           wr_ready_o,
    input  exu_pkg::alu_op_e               wr_alu_op_i,
    input  logic [`EXU_XLEN-1:0]           wr_op1_i,
    input  logic [`EXU_XLEN-1:0]           wr_op2_i,
    input  logic [`EXU_REG_ADDR_WIDTH-1:0] wr_rd_i,
    output logic                           rd_valid_o,
    input  logic                           rd_ready_i,
    output exu_pkg::alu_op_e               rd_alu_op_o,
    output logic [`EXU_XLEN-1:0]           rd_op1_o,
    output logic [`EXU_XLEN-1:0]           rd_op2_o,
    output logic [`EXU_REG_ADDR_WIDTH-1:0] rd_rd_o
);

    localparam int OP_W    = $bits(exu_pkg::alu_op_e);
    localparam int ENTRY_W = OP_W + 2 * `EXU_XLEN + `EXU_REG_ADDR_WIDTH;

    logic [ENTRY_W-1:0] mem_q [`EXU_FIFO_DEPTH];

    // extra msb tells full from empty
    logic [`EXU_FIFO_PTR_WIDTH:0] wr_ptr_q;
    logic [`EXU_FIFO_PTR_WIDTH:0] rd_ptr_q;

    logic               full;
    logic               empty;
    logic               wr_fire;
    logic               rd_fire;
    logic [ENTRY_W-1:0] head;
    logic [OP_W-1:0]    head_op;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[`EXU_FIFO_PTR_WIDTH] != rd_ptr_q[`EXU_FIFO_PTR_WIDTH]) &&
                   (wr_ptr_q[`EXU_FIFO_PTR_WIDTH-1:0] == rd_ptr_q[`EXU_FIFO_PTR_WIDTH-1:0]);

    assign wr_ready_o = !full;
    assign rd_valid_o = !empty;
    assign wr_fire    = wr_valid_i && !full;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || int_assert_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_fire) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem_q[wr_ptr_q[`EXU_FIFO_PTR_WIDTH-1:0]] <= {wr_alu_op_i, wr_op1_i, wr_op2_i, wr_rd_i};
        end
    end

    // unpack the head entry
    assign head = mem_q[rd_ptr_q[`EXU_FIFO_PTR_WIDTH-1:0]];
    assign {head_op, rd_op1_o, rd_op2_o, rd_rd_o} = head;
    assign rd_alu_op_o = exu_pkg::alu_op_e'(head_op);

endmodule

// ==== source/exu_alu.sv ====
/*
 integer ALU with a registered writeback stage
 result, rd and valid are held while wb_ready_i is low
 shifts use op2[4:0], jump link and lui/auipc arrive as ADD
 interrupt drops the pending writeback, wb_valid_o is low in that cycle
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module exu_alu (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           int_assert_i,
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  exu_pkg::alu_op_e               alu_op_i,
    input  logic [`EXU_XLEN-1:0]           alu_op1_i,
    input  logic [`EXU_XLEN-1:0]           alu_op2_i,
    input  logic [`EXU_REG_ADDR_WIDTH-1:0] alu_rd_i,
    output logic                           wb_valid_o,
    input  logic                           wb_ready_i,
    output logic [`EXU_XLEN-1:0]           wb_data_o,
    output logic [`EXU_REG_ADDR_WIDTH-1:0] wb_rd_o
);

    logic                 is_sub;
    logic [`EXU_XLEN-1:0] add_op2;
    logic [`EXU_XLEN-1:0] add_sub_res;
    logic [4:0]           shamt;
    logic [`EXU_XLEN-1:0] sll_res;
    logic [`EXU_XLEN-1:0] srl_res;
    logic [`EXU_XLEN-1:0] sr_mask;
    logic [`EXU_XLEN-1:0] sra_res;
    logic [`EXU_XLEN-1:0] slt_res;
    logic [`EXU_XLEN-1:0] sltu_res;
    logic [`EXU_XLEN-1:0] alu_res;
    logic                 req_fire;
    logic                 wb_valid_q;

    // shared adder, sub as op1 + ~op2 + 1
    assign is_sub      = (alu_op_i == exu_pkg::SUB);
    assign add_op2     = alu_op2_i ^ {`EXU_XLEN{is_sub}};
    assign add_sub_res = alu_op1_i + add_op2 + {{(`EXU_XLEN-1){1'b0}}, is_sub};

    assign shamt   = alu_op2_i[4:0];
    assign sll_res = alu_op1_i << shamt;
    assign srl_res = alu_op1_i >> shamt;
    // mask marks the bits kept by srl, the rest take the sign
    assign sr_mask = {`EXU_XLEN{1'b1}} >> shamt;
    assign sra_res = srl_res | ({`EXU_XLEN{alu_op1_i[`EXU_XLEN-1]}} & ~sr_mask);

    // set-less-than, 1 or 0
    assign slt_res  = {{(`EXU_XLEN-1){1'b0}}, $signed(alu_op1_i) < $signed(alu_op2_i)};
    assign sltu_res = {{(`EXU_XLEN-1){1'b0}}, alu_op1_i < alu_op2_i};

    always_comb begin
        case (alu_op_i)
            exu_pkg::ADD,
            exu_pkg::SUB:  alu_res = add_sub_res;
            exu_pkg::SLL:  alu_res = sll_res;
            exu_pkg::SLT:  alu_res = slt_res;
            exu_pkg::SLTU: alu_res = sltu_res;
            exu_pkg::XOR:  alu_res = alu_op1_i ^ alu_op2_i;
            exu_pkg::SRL:  alu_res = srl_res;
            exu_pkg::SRA:  alu_res = sra_res;
            exu_pkg::OR:   alu_res = alu_op1_i | alu_op2_i;
            exu_pkg::AND:  alu_res = alu_op1_i & alu_op2_i;
            default:       alu_res = '0;
        endcase
    end

    // take a request when the stage is empty or retiring now
    assign req_ready_o = wb_ready_i || !wb_valid_q;
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i || int_assert_i) begin
            wb_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            wb_valid_q <= req_valid_i;
        end
    end

    // no writeback is offered while the flush is pending
    assign wb_valid_o = wb_valid_q && !int_assert_i;

    // data and rd only move on a new request, so a stall keeps them stable
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            wb_data_o <= alu_res;
            wb_rd_o   <= alu_rd_i;
        end
    end

endmodule

// ==== source/exu_top.sv ====
/*
 execute slice, decoder -> issue queue -> ALU
 min latency from accept to wb_valid_o is 3 cycles, order is kept
 up to 6 instructions in flight, interrupt flushes all of them
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module exu_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           int_assert_i,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    input  logic [`EXU_XLEN-1:0]           instr_i,
    input  logic [`EXU_XLEN-1:0]           pc_i,
    input  logic [`EXU_XLEN-1:0]           rs1_data_i,
    input  logic [`EXU_XLEN-1:0]           rs2_data_i,
    output logic                           wb_valid_o,
    input  logic                           wb_ready_i,
    output logic [`EXU_XLEN-1:0]           wb_data_o,
    output logic [`EXU_REG_ADDR_WIDTH-1:0] wb_rd_o
);

    // decoder to queue
    logic                           dec_valid;
    logic                           dec_ready;
    exu_pkg::alu_op_e               dec_alu_op;
    logic [`EXU_XLEN-1:0]           dec_op1;
    logic [`EXU_XLEN-1:0]           dec_op2;
    logic [`EXU_REG_ADDR_WIDTH-1:0] dec_rd;

    // queue to alu
    logic                           iq_valid;
    logic                           iq_ready;
    exu_pkg::alu_op_e               iq_alu_op;
    logic [`EXU_XLEN-1:0]           iq_op1;
    logic [`EXU_XLEN-1:0]           iq_op2;
    logic [`EXU_REG_ADDR_WIDTH-1:0] iq_rd;

    idu_decode u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .int_assert_i (int_assert_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready),
        .dec_alu_op_o (dec_alu_op),
        .dec_op1_o    (dec_op1),
        .dec_op2_o    (dec_op2),
        .dec_rd_o     (dec_rd)
    );

    exu_issue_fifo u_issue_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .int_assert_i (int_assert_i),
        .wr_valid_i   (dec_valid),
        .wr_ready_o   (dec_ready),
        .wr_alu_op_i  (dec_alu_op),
        .wr_op1_i     (dec_op1),
        .wr_op2_i     (dec_op2),
        .wr_rd_i      (dec_rd),
        .rd_valid_o   (iq_valid),
        .rd_ready_i   (iq_ready),
        .rd_alu_op_o  (iq_alu_op),
        .rd_op1_o     (iq_op1),
        .rd_op2_o     (iq_op2),
        .rd_rd_o      (iq_rd)
    );

    exu_alu u_alu (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .int_assert_i (int_assert_i),
        .req_valid_i  (iq_valid),
        .req_ready_o  (iq_ready),
        .alu_op_i     (iq_alu_op),
        .alu_op1_i    (iq_op1),
        .alu_op2_i    (iq_op2),
        .alu_rd_i     (iq_rd),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_data_o    (wb_data_o),
        .wb_rd_o      (wb_rd_o)
    );

endmodule

// ==== tb/exu_checker.sv ====
/*
 watches the execute slice ports and compares every writeback
 expected results come from an RV32I reference model
 an interrupt cycle flushes all expected results
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module exu_checker (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           int_assert_i,
    input  logic                           in_valid_i,
    input  logic                           in_ready_i,
    input  logic [`EXU_XLEN-1:0]           instr_i,
    input  logic [`EXU_XLEN-1:0]           pc_i,
    input  logic [`EXU_XLEN-1:0]           rs1_data_i,
    input  logic [`EXU_XLEN-1:0]           rs2_data_i,
    input  logic                           wb_valid_i,
    input  logic                           wb_ready_i,
    input  logic [`EXU_XLEN-1:0]           wb_data_i,
    input  logic [`EXU_REG_ADDR_WIDTH-1:0] wb_rd_i,
    input  logic [2:0]                     test_id_i,
    input  logic                           done_i,
    output int                             pending_o,
    output int                             error_count_o,
    output int                             check_count_o
);

    localparam int WB_W = `EXU_XLEN + `EXU_REG_ADDR_WIDTH;

    // {data, rd} per expected writeback, oldest first
    logic [WB_W-1:0] exp_q[$];

    int   errors  = 0;
    int   checks  = 0;
    int   pending = 0;
    logic leftover_done = 1'b0;

    assign pending_o     = pending;
    assign error_count_o = errors;
    assign check_count_o = checks;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    test_name = "op_group";
            3'd2:    test_name = "op_imm_lui_auipc";
            3'd3:    test_name = "jump_and_illegal";
            3'd4:    test_name = "backpressure";
            3'd5:    test_name = "interrupt";
            default: test_name = "idle";
        endcase
    endfunction

    // returns 1 when the instruction writes back
    function automatic logic ref_exec(input logic [`EXU_XLEN-1:0] instr,
                                      input logic [`EXU_XLEN-1:0] pc,
                                      input logic [`EXU_XLEN-1:0] rs1,
                                      input logic [`EXU_XLEN-1:0] rs2,
                                      output logic [`EXU_XLEN-1:0] data,
                                      output logic [`EXU_REG_ADDR_WIDTH-1:0] rd);
        logic [`EXU_XLEN-1:0] imm_i;
        logic [`EXU_XLEN-1:0] imm_u;
        logic [`EXU_XLEN-1:0] b;
        logic [4:0]           sh;
        ref_exec = 1'b1;
        rd       = instr[11:7];
        data     = '0;
        imm_i    = {{(`EXU_XLEN-12){instr[31]}}, instr[31:20]};
        imm_u    = {instr[31:12], 12'b0};
        b        = (instr[6:0] == exu_pkg::OP) ? rs2 : imm_i;
        sh       = b[4:0];
        case (instr[6:0])
            exu_pkg::LUI:   data = imm_u;
            exu_pkg::AUIPC: data = pc + imm_u;
            // link value
            exu_pkg::JAL, exu_pkg::JALR: data = pc + 4;
            exu_pkg::OP, exu_pkg::OP_IMM: begin
                case (instr[14:12])
                    3'd0: data = (instr[30] && instr[6:0] == exu_pkg::OP) ? rs1 - b : rs1 + b;
                    3'd1: data = rs1 << sh;
                    3'd2: data = `EXU_XLEN'($signed(rs1) < $signed(b));
                    3'd3: data = `EXU_XLEN'(rs1 < b);
                    3'd4: data = rs1 ^ b;
                    3'd5: data = instr[30] ? $unsigned($signed(rs1) >>> sh) : rs1 >> sh;
                    3'd6: data = rs1 | b;
                    default: data = rs1 & b;
                endcase
            end
            default: ref_exec = 1'b0;
        endcase
    endfunction

    always @(posedge clk_i) begin
        logic [`EXU_XLEN-1:0]           exp_data;
        logic [`EXU_REG_ADDR_WIDTH-1:0] exp_rd;
        logic [WB_W-1:0]                head;
        if (rst_i || int_assert_i) begin
            // flushed instructions must never retire
            if (int_assert_i && wb_valid_i && wb_ready_i) begin
                errors++;
                $display("writeback to x%0d retired in an interrupt cycle in %s",
                         wb_rd_i, test_name(test_id_i));
            end
            exp_q.delete();
        end else begin
            if (wb_valid_i && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("writeback to x%0d data %h retired with nothing pending in %s",
                             wb_rd_i, wb_data_i, test_name(test_id_i));
                end else begin
                    head = exp_q.pop_front();
                    checks++;
                    if (head != {wb_data_i, wb_rd_i}) begin
                        errors++;
                        $display("error %s expected data %h rd %0d actual data %h rd %0d",
                                 test_name(test_id_i), head[WB_W-1:`EXU_REG_ADDR_WIDTH],
                                 head[`EXU_REG_ADDR_WIDTH-1:0], wb_data_i, wb_rd_i);
                    end
                end
            end
            if (in_valid_i && in_ready_i) begin
                if (ref_exec(instr_i, pc_i, rs1_data_i, rs2_data_i, exp_data, exp_rd)) begin
                    exp_q.push_back({exp_data, exp_rd});
                end
            end
        end
        if (done_i && !leftover_done) begin
            leftover_done = 1'b1;
            if (exp_q.size() != 0) begin
                errors++;
                $display("%0d accepted instructions were never written back", exp_q.size());
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== tb/tb_exu_top.sv ====
/*
 testbench for the execute slice, five tests run back to back
 inputs change 2 ns after the rising edge, seed 87912
 the pipeline is drained between tests so errors carry the right name
 */
`timescale 1ns/10ps
`include "exu_config.svh"

module tb_exu_top;

    localparam int N_PER_TEST = 60;
    localparam int N_TESTS    = 5;
    // 20 cycles per instruction plus room for reset and drains
    localparam int TIMEOUT_NS = (N_PER_TEST * N_TESTS * 20 + 400) * 20;

    logic                           clk_i;
    logic                           rst_i;
    logic                           int_assert_i = 1'b0;
    logic                           in_valid_i;
    logic                           in_ready_o;
    logic [`EXU_XLEN-1:0]           instr_i;
    logic [`EXU_XLEN-1:0]           pc_i;
    logic [`EXU_XLEN-1:0]           rs1_data_i;
    logic [`EXU_XLEN-1:0]           rs2_data_i;
    logic                           wb_valid_o;
    logic                           wb_ready_i = 1'b1;
    logic [`EXU_XLEN-1:0]           wb_data_o;
    logic [`EXU_REG_ADDR_WIDTH-1:0] wb_rd_o;

    integer     seed;
    logic       bp_on;
    logic       irq_on;
    logic       stall_seen;
    logic       done;
    logic [2:0] test_id;
    int         tb_errors;
    int         pending;
    int         error_count;
    int         check_count;

    exu_top DUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .int_assert_i (int_assert_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_data_o    (wb_data_o),
        .wb_rd_o      (wb_rd_o)
    );

    exu_checker u_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .int_assert_i  (int_assert_i),
        .in_valid_i    (in_valid_i),
        .in_ready_i    (in_ready_o),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .wb_valid_i    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_data_i     (wb_data_o),
        .wb_rd_i       (wb_rd_o),
        .test_id_i     (test_id),
        .done_i        (done),
        .pending_o     (pending),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // back-pressure at about 40% and rare interrupt pulses
    always @(posedge clk_i) begin
        #2;
        wb_ready_i   = !bp_on || (($unsigned($random(seed)) % 100) >= 40);
        int_assert_i = irq_on && (($unsigned($random(seed)) % 100) < 4);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // R-type word, alt is funct7 bit 30
    function automatic logic [31:0] build_r_word(input logic alt, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        build_r_word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, exu_pkg::OP};
    endfunction

    function automatic logic [31:0] build_i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
        build_i_word = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] build_u_word(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] opc);
        build_u_word = {imm, rd, opc};
    endfunction

    // kind 0 jal, 1 jalr, 2 illegal, 3 OP, 4 OP_IMM, 5 lui, 6 auipc
    task automatic make_instr(input int kind, output logic [31:0] w);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        r   = $random(seed);
        f3  = r[14:12];
        alt = r[30];
        imm = r[31:20];
        // shift immediates keep only shamt and the sra bit
        if (f3 == 3'b001) imm[11:5] = 7'b0;
        if (f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b0};
        case (kind)
            0: w = build_u_word(r[31:12], r[11:7], exu_pkg::JAL);
            1: w = build_i_word(r[31:20], r[19:15], 3'b000, r[11:7], exu_pkg::JALR);
            // load or branch opcode
            2: w = {r[31:7], (r[0] ? 7'b0000011 : 7'b1100011)};
            3: w = build_r_word(alt && (f3 == 3'b000 || f3 == 3'b101), f3, r[11:7],
                                r[19:15], r[24:20]);
            4: w = build_i_word(imm, r[19:15], f3, r[11:7], exu_pkg::OP_IMM);
            5: w = build_u_word(r[31:12], r[11:7], exu_pkg::LUI);
            default: w = build_u_word(r[31:12], r[11:7], exu_pkg::AUIPC);
        endcase
    endtask

    // hold the word until in_ready_o is seen high before an edge
    task automatic send_instr(input logic [31:0] w);
        logic rdy;
        in_valid_i = 1'b1;
        instr_i    = w;
        pc_i       = $random(seed) & 32'hFFFF_FFFC;
        rs1_data_i = $random(seed);
        rs2_data_i = $random(seed);
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk_i);
            rdy = in_ready_o;
            if (!rdy && test_id == 3'd4) stall_seen = 1'b1;
            @(posedge clk_i);
        end
        #2;
        in_valid_i = 1'b0;
    endtask

    // wait until every accepted instruction has retired or was flushed
    task automatic drain();
        int n;
        n = 0;
        while (pending != 0 && n < 200) begin
            @(posedge clk_i);
            #2;
            n++;
        end
    endtask

    task automatic run_test(input logic [2:0] id, input int first_kind, input int last_kind);
        int          kind;
        int          i;
        logic [31:0] w;
        test_id = id;
        for (i = 0; i < N_PER_TEST; i++) begin
            kind = first_kind + int'($unsigned($random(seed)) % (last_kind - first_kind + 1));
            make_instr(kind, w);
            send_instr(w);
            // an idle cycle now and then
            if ($random(seed) % 4 == 0) begin
                @(posedge clk_i);
                #2;
            end
        end
        drain();
    endtask

    initial begin
        seed       = 87912;
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        bp_on      = 1'b0;
        irq_on     = 1'b0;
        stall_seen = 1'b0;
        done       = 1'b0;
        test_id    = 3'd0;
        tb_errors  = 0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        run_test(3'd1, 3, 3);
        run_test(3'd2, 4, 6);
        run_test(3'd3, 0, 3);
        bp_on = 1'b1;
        run_test(3'd4, 0, 6);
        bp_on  = 1'b0;
        irq_on = 1'b1;
        run_test(3'd5, 0, 6);
        irq_on = 1'b0;
        drain();

        if (!stall_seen) begin
            tb_errors++;
            $display("in_ready_o never dropped while the pipeline was stalled");
        end
        // let the checker look for leftovers
        done = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        $display("errors %0d checks %0d", error_count + tb_errors, check_count);
        if (error_count + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/exu_pkg.sv
source/idu_decode.sv
source/exu_issue_fifo.sv
source/exu_alu.sv
source/exu_top.sv
tb/exu_checker.sv
tb/tb_exu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= tb.f
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
